//--- source/gray_pkg.sv
package gray_pkg;

  // Widest pointer code the helper functions handle
  localparam int code_width = 16;

  typedef logic [code_width-1:0] code_t;

  // APB register offsets
  localparam logic [3:0] data_offset    = 4'h0;
  localparam logic [3:0] status_offset  = 4'h4;
  localparam logic [3:0] control_offset = 4'h8;
  localparam logic [3:0] pointer_offset = 4'hC;

  // Status register fields
  localparam int status_level_lsb     = 0;
  localparam int status_level_msb     = 7;
  localparam int status_empty_bit     = 8;
  localparam int status_full_bit      = 9;
  localparam int status_overflow_bit  = 10;
  localparam int status_underflow_bit = 11;

  // Pointer width for a FIFO of the given depth, counting over twice the depth
  function automatic int pointer_width(input int depth);
    return $clog2(2 * depth);
  endfunction

  // Shift that centres an even range inside the power-of-two code space,
  // so the code is symmetric and the wrap changes a single bit
  function automatic code_t gray_offset(input int range);
    int width;
    width = $clog2(range);
    return code_t'(((1 << width) - range) / 2);
  endfunction

  // Gray code of a count in [0, range-1], range even
  function automatic code_t binary_to_gray(input code_t count, input int range);
    code_t shifted;
    shifted = count + gray_offset(range);
    return shifted ^ (shifted >> 1);
  endfunction

  // Inverse of binary_to_gray for the same range
  function automatic code_t gray_to_binary(input code_t gray, input int range);
    code_t binary;
    binary = '0;
    binary[code_width-1] = gray[code_width-1];
    // Prefix XOR from the top bit down
    for (int i = code_width - 2; i >= 0; i--) begin
      binary[i] = binary[i+1] ^ gray[i];
    end
    return binary - gray_offset(range);
  endfunction

endpackage

//--- source/gray_wrapping_counter.sv
module gray_wrapping_counter #(
  parameter  int range = 12,
  localparam int width = gray_pkg::pointer_width(range / 2)
) (
  input  logic             clock,
  input  logic             resetn,
  input  logic             load_enable,
  input  logic [width-1:0] load_count,
  input  logic             increment,
  output logic [width-1:0] count_gray,
  output logic [width-1:0] count_binary
);

  // Last value before the count wraps back to zero
  localparam logic [width-1:0] last_count = width'(range - 1);

  // Gray value held while in reset
  localparam gray_pkg::code_t reset_gray = gray_pkg::binary_to_gray('0, range);

  logic [width-1:0] next_binary;
  gray_pkg::code_t  next_gray;

  // Next binary count
  // Load takes priority over increment
  always_comb begin
    if (load_enable) begin
      next_binary = load_count;
    end else if (increment) begin
      if (count_binary == last_count) begin
        next_binary = '0;
      end else begin
        next_binary = count_binary + 1'b1;
      end
    end else begin
      next_binary = count_binary;
    end
  end

  // Gray copy follows the binary count through the shared encoder
  assign next_gray = gray_pkg::binary_to_gray(gray_pkg::code_t'(next_binary), range);

  // Both copies are registered side by side
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      count_binary <= '0;
      count_gray   <= reset_gray[width-1:0];
    end else begin
      count_binary <= next_binary;
      count_gray   <= next_gray[width-1:0];
    end
  end

  // The centred code only stays cyclic for an even range
  range_even: assert property (
    @(posedge clock) disable iff (!resetn)
    (range % 2) == 0
  ) else $error("gray_wrapping_counter: range %0d is odd", range);

  // Binary count never leaves the wrapping range
  count_in_range: assert property (
    @(posedge clock) disable iff (!resetn)
    count_binary <= last_count
  ) else $error("gray_wrapping_counter: count %0d out of range", count_binary);

  // One step of the counter flips exactly one Gray bit, wrap included
  gray_single_step: assert property (
    @(posedge clock) disable iff (!resetn)
    increment && !load_enable |=> $countones(count_gray ^ $past(count_gray)) == 1
  ) else $error("gray_wrapping_counter: Gray step changed more than one bit");

endmodule

//--- source/fifo_storage.sv
module fifo_storage #(
  parameter  int depth         = 6,
  parameter  int data_width    = 16,
  localparam int pointer_width = gray_pkg::pointer_width(depth),
  localparam int address_width = pointer_width - 1
) (
  input  logic                     clock,
  input  logic                     resetn,
  input  logic                     write_enable,
  input  logic [pointer_width-1:0] write_pointer,
  input  logic [data_width-1:0]    write_data,
  input  logic                     read_enable,
  input  logic [pointer_width-1:0] read_pointer,
  output logic [data_width-1:0]    read_data
);

  localparam logic [pointer_width-1:0] depth_value = pointer_width'(depth);

  logic [data_width-1:0]    memory [depth];
  logic [pointer_width-1:0] write_index;
  logic [pointer_width-1:0] read_index;

  // Pointers run over twice the depth, fold them onto the array
  assign write_index = (write_pointer >= depth_value) ? write_pointer - depth_value
                                                      : write_pointer;
  assign read_index  = (read_pointer >= depth_value) ? read_pointer - depth_value
                                                     : read_pointer;

  always_ff @(posedge clock) begin
    if (write_enable) begin
      memory[write_index[address_width-1:0]] <= write_data;
    end
    // Head word captured at the same edge the read pointer advances
    if (read_enable) begin
      read_data <= memory[read_index[address_width-1:0]];
    end
  end

  // Same slot read and written at once means full and empty together
  no_slot_collision: assert property (
    @(posedge clock) disable iff (!resetn)
    !(write_enable && read_enable && write_index == read_index)
  ) else $error("fifo_storage: read and write hit slot %0d together", write_index);

endmodule

//--- source/fifo_occupancy.sv
module fifo_occupancy #(
  parameter  int depth         = 6,
  localparam int pointer_width = gray_pkg::pointer_width(depth)
) (
  input  logic [pointer_width-1:0] write_gray,
  input  logic [pointer_width-1:0] read_gray,
  output logic [pointer_width-1:0] level,
  output logic                     empty,
  output logic                     full
);

  // Pointer range, one bit wider so a power-of-two range still fits
  localparam logic [pointer_width:0] range_value = (pointer_width + 1)'(2 * depth);

  gray_pkg::code_t        write_decoded;
  gray_pkg::code_t        read_decoded;
  logic [pointer_width:0] write_binary;
  logic [pointer_width:0] read_binary;
  logic [pointer_width:0] difference;

  assign write_decoded = gray_pkg::gray_to_binary(gray_pkg::code_t'(write_gray), 2 * depth);
  assign read_decoded  = gray_pkg::gray_to_binary(gray_pkg::code_t'(read_gray), 2 * depth);

  assign write_binary = {1'b0, write_decoded[pointer_width-1:0]};
  assign read_binary  = {1'b0, read_decoded[pointer_width-1:0]};

  // Distance from read to write modulo the pointer range
  always_comb begin
    if (write_binary >= read_binary) begin
      difference = write_binary - read_binary;
    end else begin
      difference = write_binary + range_value - read_binary;
    end
  end

  assign level = difference[pointer_width-1:0];
  assign empty = level == '0;
  assign full  = level == pointer_width'(depth);

  // Pointers more than depth apart mean a push was let through while full
  always_comb begin
    level_bounded: assert ($isunknown(difference) || difference <= depth)
      else $error("fifo_occupancy: level %0d above depth %0d", difference, depth);
  end

endmodule

//--- source/apb_fifo_regs.sv
module apb_fifo_regs #(
  parameter  int depth         = 6,
  parameter  int data_width    = 16,
  localparam int pointer_width = gray_pkg::pointer_width(depth)
) (
  input  logic                     clock,
  input  logic                     resetn,
  // APB slave
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [3:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  // FIFO control
  output logic                     push,
  output logic                     pop,
  output logic                     clear,
  output logic [data_width-1:0]    write_data,
  input  logic [data_width-1:0]    read_data,
  // FIFO state
  input  logic [pointer_width-1:0] level,
  input  logic                     empty,
  input  logic                     full,
  input  logic [pointer_width-1:0] write_gray,
  input  logic [pointer_width-1:0] read_gray
);

  logic        access;
  logic        mapped;
  logic        data_write;
  logic        data_read;
  logic        read_first;
  logic        read_pending;
  logic        read_refused;
  logic        overflow;
  logic        underflow;
  logic [31:0] status_word;
  logic [31:0] pointer_word;

  assign access = psel && penable;

  // Only word-aligned offsets are mapped
  assign mapped     = paddr[1:0] == 2'b00;
  assign data_write = access && pwrite && paddr == gray_pkg::data_offset;
  assign data_read  = access && !pwrite && paddr == gray_pkg::data_offset;

  // First access cycle of a data read pops the head word
  assign read_first = data_read && !read_pending;

  // Data reads take one wait state and everything else completes at once
  assign pready = access && (!data_read || read_pending);

  assign push  = data_write && !full;
  assign pop   = read_first && !empty;
  assign clear = access && pwrite && paddr == gray_pkg::control_offset;

  assign pslverr = pready && (!mapped || (data_write && full) || (data_read && read_refused));

  assign write_data = pwdata[data_width-1:0];

  // Wait state tracking and sticky errors
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      read_pending <= 1'b0;
      read_refused <= 1'b0;
      overflow     <= 1'b0;
      underflow    <= 1'b0;
    end else begin
      read_pending <= read_first;
      if (read_first) begin
        read_refused <= empty;
      end
      if (clear) begin
        overflow  <= 1'b0;
        underflow <= 1'b0;
      end else begin
        if (data_write && full) begin
          overflow <= 1'b1;
        end
        if (read_first && empty) begin
          underflow <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    status_word = '0;
    status_word[gray_pkg::status_level_msb:gray_pkg::status_level_lsb] = 8'(level);
    status_word[gray_pkg::status_empty_bit]     = empty;
    status_word[gray_pkg::status_full_bit]      = full;
    status_word[gray_pkg::status_overflow_bit]  = overflow;
    status_word[gray_pkg::status_underflow_bit] = underflow;
  end

  // Write pointer in the low byte and read pointer in the next byte
  always_comb begin
    pointer_word        = '0;
    pointer_word[7:0]   = 8'(write_gray);
    pointer_word[15:8]  = 8'(read_gray);
  end

  // Read data mux where control reads back as zero
  always_comb begin
    prdata = '0;
    case (paddr)
      gray_pkg::data_offset:    prdata[data_width-1:0] = read_data;
      gray_pkg::status_offset:  prdata = status_word;
      gray_pkg::pointer_offset: prdata = pointer_word;
      default:                  prdata = '0;
    endcase
  end

  // Each push or pop moves the level by one on the next cycle
  level_steps_by_one: assert property (
    @(posedge clock) disable iff (!resetn)
    push || pop |=> level == ($past(push) ? $past(level) + 1'b1 : $past(level) - 1'b1)
  ) else $error("apb_fifo_regs: level did not follow a push or pop");

  // A data read stays on the bus through its wait state so the popped word reaches prdata
  read_held_in_wait: assert property (
    @(posedge clock) disable iff (!resetn)
    data_read && !pready |=> psel && penable && !pwrite && paddr == gray_pkg::data_offset
  ) else $error("apb_fifo_regs: data read dropped during its wait state");

endmodule

//--- source/apb_gray_fifo.sv
module apb_gray_fifo #(
  parameter int depth      = 6,
  parameter int data_width = 16
) (
  input  logic        clock,
  input  logic        resetn,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int pointer_width = gray_pkg::pointer_width(depth);

  logic                     push;
  logic                     pop;
  logic                     clear;
  logic [data_width-1:0]    write_data;
  logic [data_width-1:0]    read_data;
  logic [pointer_width-1:0] level;
  logic                     empty;
  logic                     full;
  logic [pointer_width-1:0] write_gray;
  logic [pointer_width-1:0] read_gray;
  logic [pointer_width-1:0] write_binary;
  logic [pointer_width-1:0] read_binary;

  apb_fifo_regs #(
    .depth      (depth),
    .data_width (data_width)
  ) u_apb_fifo_regs (
    .clock      (clock),
    .resetn     (resetn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .push       (push),
    .pop        (pop),
    .clear      (clear),
    .write_data (write_data),
    .read_data  (read_data),
    .level      (level),
    .empty      (empty),
    .full       (full),
    .write_gray (write_gray),
    .read_gray  (read_gray)
  );

  // Clear reloads both pointers with zero
  gray_wrapping_counter #(
    .range (2 * depth)
  ) write_pointer_counter (
    .clock        (clock),
    .resetn       (resetn),
    .load_enable  (clear),
    .load_count   ('0),
    .increment    (push),
    .count_gray   (write_gray),
    .count_binary (write_binary)
  );

  gray_wrapping_counter #(
    .range (2 * depth)
  ) read_pointer_counter (
    .clock        (clock),
    .resetn       (resetn),
    .load_enable  (clear),
    .load_count   ('0),
    .increment    (pop),
    .count_gray   (read_gray),
    .count_binary (read_binary)
  );

  fifo_storage #(
    .depth      (depth),
    .data_width (data_width)
  ) u_fifo_storage (
    .clock         (clock),
    .resetn        (resetn),
    .write_enable  (push),
    .write_pointer (write_binary),
    .write_data    (write_data),
    .read_enable   (pop),
    .read_pointer  (read_binary),
    .read_data     (read_data)
  );

  fifo_occupancy #(
    .depth (depth)
  ) u_fifo_occupancy (
    .write_gray (write_gray),
    .read_gray  (read_gray),
    .level      (level),
    .empty      (empty),
    .full       (full)
  );

endmodule

//--- testbench/apb_gray_fifo_tb.sv
module apb_gray_fifo_tb;

  localparam int depth      = 6;
  localparam int data_width = 16;
  localparam int range      = 2 * depth;
  // About 650 transfers of up to 4 cycles each, plus reset and a wide margin
  localparam int cycle_limit = 6000;

  logic        clock;
  logic        resetn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Reference model state
  logic [data_width-1:0] model_queue[$];
  int   write_count;
  int   read_count;
  logic overflow_flag;
  logic underflow_flag;

  // Last completed transfer as seen on the bus
  logic        last_write;
  logic [3:0]  last_addr;
  logic [31:0] last_wdata;
  logic [31:0] seen_rdata;
  logic        seen_err;
  int          last_waits;
  event        transfer_done;

  logic       track_steps;
  logic       step_seen;
  logic [7:0] prev_write_gray;
  logic [7:0] prev_read_gray;

  int check_count;
  int error_count;
  int errors_at_start;
  int cycle_count;
  int seed = 77;

  apb_gray_fifo #(
    .depth      (depth),
    .data_width (data_width)
  ) u_apb_gray_fifo (
    .clock   (clock),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Expected Gray code with the count shifted to the middle of the power-of-two space
  function automatic int expected_gray(input int count);
    int width;
    int shifted;
    width = 0;
    while ((1 << width) < range) begin
      width++;
    end
    shifted = count + ((1 << width) - range) / 2;
    return shifted ^ (shifted >> 1);
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] word;
    word = '0;
    word[7:0] = 8'(model_queue.size());
    word[gray_pkg::status_empty_bit]     = model_queue.size() == 0;
    word[gray_pkg::status_full_bit]      = model_queue.size() == depth;
    word[gray_pkg::status_overflow_bit]  = overflow_flag;
    word[gray_pkg::status_underflow_bit] = underflow_flag;
    return word;
  endfunction

  function automatic logic [31:0] expected_pointer();
    logic [31:0] word;
    word = '0;
    word[7:0]  = 8'(expected_gray(write_count));
    word[15:8] = 8'(expected_gray(read_count));
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  // Setup, access, then wait for pready; outputs sampled on the falling edge
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata);
    int waits;
    waits = 0;
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    while (!pready) begin
      waits++;
      @(negedge clock);
    end
    last_write = write;
    last_addr  = addr;
    last_wdata = wdata;
    seen_rdata = prdata;
    seen_err   = pslverr;
    last_waits = waits;
    -> transfer_done;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d errors", name, error_count - errors_at_start);
    errors_at_start = error_count;
  endtask

  // Reference model update and comparison for every completed transfer
  always @(transfer_done) begin
    logic expected_err;
    int   expected_waits;
    expected_err = 1'b0;
    // Only a data read takes a wait state
    expected_waits = (last_addr == gray_pkg::data_offset && !last_write) ? 1 : 0;
    if (last_addr == gray_pkg::data_offset && last_write) begin
      expected_err = model_queue.size() == depth;
      if (expected_err) begin
        overflow_flag = 1'b1;
      end else begin
        model_queue.push_back(last_wdata[data_width-1:0]);
        write_count = (write_count + 1) % range;
      end
    end else if (last_addr == gray_pkg::data_offset) begin
      expected_err = model_queue.size() == 0;
      if (expected_err) begin
        underflow_flag = 1'b1;
      end else begin
        check_value("prdata (data)", seen_rdata, 32'(model_queue.pop_front()));
        read_count = (read_count + 1) % range;
      end
    end else if (last_addr == gray_pkg::status_offset && !last_write) begin
      check_value("prdata (status)", seen_rdata, expected_status());
    end else if (last_addr == gray_pkg::pointer_offset && !last_write) begin
      check_value("prdata (pointer)", seen_rdata, expected_pointer());
      if (track_steps && step_seen) begin
        if ($countones(seen_rdata[7:0] ^ prev_write_gray) > 1) begin
          error_count++;
          $display("write pointer changed in more than one bit between readings");
        end
        if ($countones(seen_rdata[15:8] ^ prev_read_gray) > 1) begin
          error_count++;
          $display("read pointer changed in more than one bit between readings");
        end
      end
      prev_write_gray = seen_rdata[7:0];
      prev_read_gray  = seen_rdata[15:8];
      step_seen       = 1'b1;
    end else if (last_addr == gray_pkg::control_offset && last_write) begin
      model_queue.delete();
      write_count    = 0;
      read_count     = 0;
      overflow_flag  = 1'b0;
      underflow_flag = 1'b0;
    end
    check_value("pslverr", 32'(seen_err), 32'(expected_err));
    check_value("pready wait cycles", 32'(last_waits), 32'(expected_waits));
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    int   choice;
    logic do_push;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    resetn = 1'b0;
    write_count = 0;
    read_count = 0;
    overflow_flag = 1'b0;
    underflow_flag = 1'b0;
    track_steps = 1'b0;
    step_seen = 1'b0;
    check_count = 0;
    error_count = 0;
    errors_at_start = 0;
    cycle_count = 0;
    repeat (16) @(posedge clock);
    resetn <= 1'b1;

    apb_transfer(1'b0, gray_pkg::status_offset, '0);
    apb_transfer(1'b0, gray_pkg::pointer_offset, '0);
    finish_test("1 reset state");

    // Status after each transfer shows the level stepping by one
    for (int i = 0; i < 8; i++) begin
      apb_transfer(i < 4, gray_pkg::data_offset, $random(seed));
      apb_transfer(1'b0, gray_pkg::status_offset, '0);
    end
    finish_test("2 push and pop four words");

    for (int i = 0; i <= depth; i++) begin
      apb_transfer(1'b1, gray_pkg::data_offset, $random(seed));
    end
    apb_transfer(1'b0, gray_pkg::status_offset, '0);
    for (int i = 0; i < depth; i++) begin
      apb_transfer(1'b0, gray_pkg::data_offset, '0);
    end
    apb_transfer(1'b0, gray_pkg::status_offset, '0);
    finish_test("3 overflow when full");

    apb_transfer(1'b0, gray_pkg::data_offset, '0);
    apb_transfer(1'b0, gray_pkg::status_offset, '0);
    apb_transfer(1'b1, gray_pkg::control_offset, '0);
    apb_transfer(1'b0, gray_pkg::status_offset, '0);
    apb_transfer(1'b0, gray_pkg::pointer_offset, '0);
    finish_test("4 underflow and clear");

    // Only legal operations, so pushes never meet a full FIFO
    track_steps = 1'b1;
    step_seen   = 1'b0;
    for (int i = 0; i < 200; i++) begin
      choice = $random(seed);
      if (model_queue.size() == 0) begin
        do_push = 1'b1;
      end else if (model_queue.size() == depth) begin
        do_push = 1'b0;
      end else begin
        do_push = choice[0];
      end
      apb_transfer(do_push, gray_pkg::data_offset, do_push ? $random(seed) : 0);
      apb_transfer(1'b0, gray_pkg::status_offset, '0);
      apb_transfer(1'b0, gray_pkg::pointer_offset, '0);
    end
    finish_test("5 random traffic");

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- files.f
source/gray_pkg.sv
source/gray_wrapping_counter.sv
source/fifo_storage.sv
source/fifo_occupancy.sv
source/apb_fifo_regs.sv
source/apb_gray_fifo.sv
testbench/apb_gray_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the APB Gray FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module apb_gray_fifo_tb -Mdir build/obj_dir -f files.f

output=$(./build/obj_dir/Vapb_gray_fifo_tb)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
